/* fm_cfg_pkg.sv */
package fm_cfg_pkg;

   // Frequencies in Hz
   localparam int FM_HZ_W = 27;
   localparam logic [FM_HZ_W-1:0] FM_CLK_HZ  = 27'd67_500_000;
   localparam logic [FM_HZ_W-1:0] FM_BASE_HZ = 27'd30_000_000;

   // Sample RAM geometry
   localparam int RAM_AW   = 11;
   localparam int RAM_DW   = 16;
   localparam int SHIFT_W  = 15;
   localparam int PERIOD_W = 16;

   // Command codes, low nibble of each received byte
   localparam logic [3:0] CMD_DATA0 = 4'h0;
   localparam logic [3:0] CMD_DATA1 = 4'h1;
   localparam logic [3:0] CMD_DATA2 = 4'h2;
   localparam logic [3:0] CMD_DATA3 = 4'h3;
   localparam logic [3:0] CMD_ADDR0 = 4'h4;
   localparam logic [3:0] CMD_ADDR1 = 4'h5;
   localparam logic [3:0] CMD_ADDR2 = 4'h6;
   localparam logic [3:0] CMD_READ  = 4'h7;
   localparam logic [3:0] CMD_WRITE = 4'h8;
   localparam logic [3:0] CMD_PER0  = 4'h9;
   localparam logic [3:0] CMD_PER1  = 4'hA;
   localparam logic [3:0] CMD_PER2  = 4'hB;
   localparam logic [3:0] CMD_PER3  = 4'hC;
   localparam logic [3:0] CMD_SET   = 4'hD;
   localparam logic [3:0] CMD_TXLO  = 4'hE;
   localparam logic [3:0] CMD_TXHI  = 4'hF;

endpackage

/* uart_pkg.sv */
package uart_pkg;

   // Fixed bit time in pll_clk cycles
   localparam int UART_CLKS_PER_BIT = 16;
   localparam int UART_DATA_BITS    = 8;

   // Counter widths
   localparam int UART_CNT_W = $clog2(UART_CLKS_PER_BIT);
   localparam int UART_BIT_W = $clog2(UART_DATA_BITS);

endpackage

/* uart_txrx.sv */
`timescale 1ns/1ns
module uart_txrx import uart_pkg::*; (
   input  logic       pll_clk,
   input  logic       i_nrst,
   input  logic       i_rx,
   input  logic       i_tx_start,
   input  logic [7:0] i_tx_data,
   output logic       o_rx_valid,
   output logic [7:0] o_rx_data,
   output logic       o_tx,
   output logic       o_tx_busy
);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

   rx_state_t                 rx_state;
   logic [2:0]                rx_sync;
   logic [UART_CNT_W-1:0]     rx_cnt;
   logic [UART_BIT_W-1:0]     rx_bit;
   logic [UART_DATA_BITS-1:0] rx_shift;

   logic [UART_CNT_W-1:0]     tx_cnt;
   logic [UART_BIT_W:0]       tx_left;
   logic [UART_DATA_BITS:0]   tx_shift;

   //////////////////////////////
   // Receiver
   assign o_rx_data = rx_shift;

   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_sync    <= '1;
         rx_state   <= RX_IDLE;
         rx_cnt     <= '0;
         rx_bit     <= '0;
         rx_shift   <= '0;
         o_rx_valid <= 1'b0;
      end else begin
         rx_sync    <= {rx_sync[1:0], i_rx};
         o_rx_valid <= 1'b0;
         case (rx_state)
            RX_IDLE: begin
               rx_cnt <= '0;
               if (!rx_sync[2])
                  rx_state <= RX_START;
            end
            RX_START: begin
               // Middle of start bit, reject glitches
               if (rx_cnt == UART_CNT_W'(UART_CLKS_PER_BIT / 2 - 1)) begin
                  rx_cnt   <= '0;
                  rx_bit   <= '0;
                  rx_state <= rx_sync[2] ? RX_IDLE : RX_DATA;
               end else begin
                  rx_cnt <= rx_cnt + 1'b1;
               end
            end
            RX_DATA: begin
               if (rx_cnt == UART_CNT_W'(UART_CLKS_PER_BIT - 1)) begin
                  rx_cnt   <= '0;
                  rx_shift <= {rx_sync[2], rx_shift[UART_DATA_BITS-1:1]};
                  rx_bit   <= rx_bit + 1'b1;
                  if (rx_bit == UART_BIT_W'(UART_DATA_BITS - 1))
                     rx_state <= RX_STOP;
               end else begin
                  rx_cnt <= rx_cnt + 1'b1;
               end
            end
            default: begin
               if (rx_cnt == UART_CNT_W'(UART_CLKS_PER_BIT - 1)) begin
                  o_rx_valid <= rx_sync[2];
                  rx_state   <= RX_IDLE;
               end else begin
                  rx_cnt <= rx_cnt + 1'b1;
               end
            end
         endcase
      end
   end

   //////////////////////////////
   // Transmitter
   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_tx      <= 1'b1;
         o_tx_busy <= 1'b0;
         tx_cnt    <= '0;
         tx_left   <= '0;
         tx_shift  <= '1;
      end else if (!o_tx_busy) begin
         if (i_tx_start) begin
            o_tx      <= 1'b0;
            o_tx_busy <= 1'b1;
            tx_cnt    <= '0;
            tx_left   <= (UART_BIT_W + 1)'(UART_DATA_BITS + 1);
            tx_shift  <= {1'b1, i_tx_data};
         end
      end else if (tx_cnt == UART_CNT_W'(UART_CLKS_PER_BIT - 1)) begin
         tx_cnt <= '0;
         if (tx_left == '0) begin
            o_tx_busy <= 1'b0;
         end else begin
            // Data bits then stop bit
            o_tx     <= tx_shift[0];
            tx_shift <= {1'b1, tx_shift[UART_DATA_BITS:1]};
            tx_left  <= tx_left - 1'b1;
         end
      end else begin
         tx_cnt <= tx_cnt + 1'b1;
      end
   end

endmodule

/* cmd_decoder.sv */
`timescale 1ns/1ns
module cmd_decoder import fm_cfg_pkg::*; (
   input  logic                pll_clk,
   input  logic                i_nrst,
   input  logic                i_rx_valid,
   input  logic [7:0]          i_rx_data,
   input  logic                i_tx_busy,
   output logic                o_tx_start,
   output logic [7:0]          o_tx_data,
   output logic [RAM_AW-1:0]   o_ram_addr,
   output logic [RAM_DW-1:0]   o_ram_wdata,
   output logic                o_ram_we,
   output logic                o_rd_req,
   input  logic                i_rd_ack,
   input  logic [RAM_DW-1:0]   i_ram_rdata,
   output logic [PERIOD_W-1:0] o_period,
   output logic                o_fm_set
);

   logic [3:0] nib;

   assign nib = i_rx_data[7:4];

   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_tx_start  <= 1'b0;
         o_tx_data   <= '0;
         o_ram_addr  <= '0;
         o_ram_wdata <= '0;
         o_ram_we    <= 1'b0;
         o_rd_req    <= 1'b0;
         o_period    <= '0;
         o_fm_set    <= 1'b0;
      end else begin
         // Strobes last one clock
         o_tx_start <= 1'b0;
         o_ram_we   <= 1'b0;
         o_fm_set   <= 1'b0;
         if (i_rx_valid) begin
            case (i_rx_data[3:0])
               CMD_DATA0: o_ram_wdata[3:0]   <= nib;
               CMD_DATA1: o_ram_wdata[7:4]   <= nib;
               CMD_DATA2: o_ram_wdata[11:8]  <= nib;
               CMD_DATA3: o_ram_wdata[15:12] <= nib;
               CMD_ADDR0: o_ram_addr[3:0]    <= nib;
               CMD_ADDR1: o_ram_addr[7:4]    <= nib;
               CMD_ADDR2: o_ram_addr[10:8]   <= nib[2:0];
               CMD_READ:  if (!i_rd_ack) o_rd_req <= 1'b1;
               CMD_WRITE: o_ram_we           <= 1'b1;
               CMD_PER0:  o_period[3:0]      <= nib;
               CMD_PER1:  o_period[7:4]      <= nib;
               CMD_PER2:  o_period[11:8]     <= nib;
               CMD_PER3:  o_period[15:12]    <= nib;
               CMD_SET:   o_fm_set           <= 1'b1;
               CMD_TXLO: begin
                  if (!i_tx_busy) begin
                     o_tx_data  <= o_ram_wdata[7:0];
                     o_tx_start <= 1'b1;
                  end
               end
               default: begin
                  if (!i_tx_busy) begin
                     o_tx_data  <= o_ram_wdata[15:8];
                     o_tx_start <= 1'b1;
                  end
               end
            endcase
         end
         // First ack clock ends the read
         if (o_rd_req && i_rd_ack) begin
            o_ram_wdata <= i_ram_rdata;
            o_rd_req    <= 1'b0;
         end
      end
   end

endmodule

/* arb_rr2.sv */
`timescale 1ns/1ns
module arb_rr2 #(
   parameter type t_payload = logic
) (
   input  logic     pll_clk,
   input  logic     i_nrst,
   input  logic     i_req0,
   input  t_payload i_data0,
   output logic     o_ack0,
   input  logic     i_req1,
   input  t_payload i_data1,
   output logic     o_ack1,
   output logic     o_ram_re,
   output t_payload o_ram_raddr
);

   typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_ACK} arb_state_t;

   arb_state_t state;
   logic       last;
   logic       gnt1;

   // Requester 1 wins unless both wait and it was served last
   assign gnt1 = i_req1 && (!i_req0 || !last);

   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state    <= ST_IDLE;
         last     <= 1'b0;
         o_ram_re <= 1'b0;
         o_ack0   <= 1'b0;
         o_ack1   <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (i_req0 || i_req1) begin
                  last     <= gnt1;
                  o_ram_re <= 1'b1;
                  state    <= ST_READ;
               end
            end
            ST_READ: begin
               o_ram_re <= 1'b0;
               o_ack0   <= !last;
               o_ack1   <= last;
               state    <= ST_ACK;
            end
            default: begin
               if (!(last ? i_req1 : i_req0)) begin
                  o_ack0 <= 1'b0;
                  o_ack1 <= 1'b0;
                  state  <= ST_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge pll_clk) begin
      if (state == ST_IDLE && (i_req0 || i_req1))
         o_ram_raddr <= gnt1 ? i_data1 : i_data0;
   end

endmodule

/* sample_ram.sv */
`timescale 1ns/1ns
module sample_ram import fm_cfg_pkg::*; (
   input  logic              pll_clk,
   input  logic              i_we,
   input  logic [RAM_AW-1:0] i_waddr,
   input  logic [RAM_DW-1:0] i_wdata,
   input  logic              i_re,
   input  logic [RAM_AW-1:0] i_raddr,
   output logic [RAM_DW-1:0] o_rdata
);

   logic [RAM_DW-1:0] mem [2**RAM_AW];

   always_ff @(posedge pll_clk) begin
      if (i_we)
         mem[i_waddr] <= i_wdata;
      // Read data holds between reads
      if (i_re)
         o_rdata <= mem[i_raddr];
   end

endmodule

/* fm_player.sv */
`timescale 1ns/1ns
module fm_player import fm_cfg_pkg::*; (
   input  logic                pll_clk,
   input  logic                i_nrst,
   input  logic [PERIOD_W-1:0] i_period,
   output logic                o_rd_req,
   output logic [RAM_AW-1:0]   o_rd_addr,
   input  logic                i_rd_ack,
   input  logic [RAM_DW-1:0]   i_ram_rdata,
   output logic [SHIFT_W-1:0]  o_shift
);

   logic [PERIOD_W-1:0] cnt;
   logic                stop;
   logic                sample;

   // Wait for the previous read to finish before stepping
   assign sample = (i_period != '0) && (cnt >= i_period) && !o_rd_req && !i_rd_ack;

   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         cnt       <= '0;
         stop      <= 1'b1;
         o_rd_req  <= 1'b0;
         o_rd_addr <= '0;
         o_shift   <= '0;
      end else begin
         if (i_period == '0 || sample)
            cnt <= '0;
         else if (cnt < i_period)
            cnt <= cnt + 1'b1;

         if (sample) begin
            // Stop flag set at reset, so playback begins at address 0
            o_rd_addr <= stop ? '0 : o_rd_addr + 1'b1;
            o_rd_req  <= 1'b1;
         end

         if (o_rd_req && i_rd_ack) begin
            o_rd_req <= 1'b0;
            stop     <= i_ram_rdata[RAM_DW-1];
            o_shift  <= i_ram_rdata[SHIFT_W-1:0];
         end
      end
   end

endmodule

/* fm_nco.sv */
`timescale 1ns/1ns
module fm_nco import fm_cfg_pkg::*; (
   input  logic               pll_clk,
   input  logic               i_nrst,
   input  logic [SHIFT_W-1:0] i_shift,
   input  logic               i_set,
   output logic               o_fm
);

   logic [FM_HZ_W-1:0] freq;
   logic [FM_HZ_W-1:0] acc;
   logic [FM_HZ_W:0]   sum;
   logic               run;

   // Two half periods per carrier cycle
   assign sum = {1'b0, acc} + {freq, 1'b0};

   always_ff @(posedge pll_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         freq <= FM_BASE_HZ;
         acc  <= '0;
         run  <= 1'b0;
         o_fm <= 1'b0;
      end else begin
         if (i_set) begin
            freq <= FM_BASE_HZ + FM_HZ_W'(i_shift);
            run  <= 1'b1;
         end
         // Idle until the first set
         if (run) begin
            if (sum >= {1'b0, FM_CLK_HZ}) begin
               acc  <= FM_HZ_W'(sum - {1'b0, FM_CLK_HZ});
               o_fm <= !o_fm;
            end else begin
               acc <= FM_HZ_W'(sum);
            end
         end
      end
   end

endmodule

/* fm_tx_top.sv */
`timescale 1ns/1ns
module fm_tx_top import fm_cfg_pkg::*; (
   input  logic pll_clk,
   input  logic i_nrst,
   input  logic i_rx,
   output logic o_tx,
   output logic o_fm
);

   logic                rx_valid;
   logic [7:0]          rx_data;
   logic                tx_start;
   logic [7:0]          tx_data;
   logic                tx_busy;

   logic [RAM_AW-1:0]   dec_addr;
   logic [RAM_DW-1:0]   dec_wdata;
   logic                dec_we;
   logic                dec_req;
   logic                dec_ack;
   logic [PERIOD_W-1:0] period;
   logic                fm_set;

   logic                ply_req;
   logic [RAM_AW-1:0]   ply_addr;
   logic                ply_ack;
   logic [SHIFT_W-1:0]  shift;

   logic                ram_re;
   logic [RAM_AW-1:0]   ram_raddr;
   logic [RAM_DW-1:0]   ram_rdata;

   //////////////////////////////
   // Serial port and commands
   uart_txrx uart_txrx_inst (
      .pll_clk    (pll_clk),
      .i_nrst     (i_nrst),
      .i_rx       (i_rx),
      .i_tx_start (tx_start),
      .i_tx_data  (tx_data),
      .o_rx_valid (rx_valid),
      .o_rx_data  (rx_data),
      .o_tx       (o_tx),
      .o_tx_busy  (tx_busy)
   );

   cmd_decoder cmd_decoder_inst (
      .pll_clk     (pll_clk),
      .i_nrst      (i_nrst),
      .i_rx_valid  (rx_valid),
      .i_rx_data   (rx_data),
      .i_tx_busy   (tx_busy),
      .o_tx_start  (tx_start),
      .o_tx_data   (tx_data),
      .o_ram_addr  (dec_addr),
      .o_ram_wdata (dec_wdata),
      .o_ram_we    (dec_we),
      .o_rd_req    (dec_req),
      .i_rd_ack    (dec_ack),
      .i_ram_rdata (ram_rdata),
      .o_period    (period),
      .o_fm_set    (fm_set)
   );

   //////////////////////////////
   // Sample RAM, decoder on port 0
   arb_rr2 #(
      .t_payload (logic [RAM_AW-1:0])
   ) arb_rr2_inst (
      .pll_clk     (pll_clk),
      .i_nrst      (i_nrst),
      .i_req0      (dec_req),
      .i_data0     (dec_addr),
      .o_ack0      (dec_ack),
      .i_req1      (ply_req),
      .i_data1     (ply_addr),
      .o_ack1      (ply_ack),
      .o_ram_re    (ram_re),
      .o_ram_raddr (ram_raddr)
   );

   sample_ram sample_ram_inst (
      .pll_clk (pll_clk),
      .i_we    (dec_we),
      .i_waddr (dec_addr),
      .i_wdata (dec_wdata),
      .i_re    (ram_re),
      .i_raddr (ram_raddr),
      .o_rdata (ram_rdata)
   );

   //////////////////////////////
   // Playback and carrier
   fm_player fm_player_inst (
      .pll_clk     (pll_clk),
      .i_nrst      (i_nrst),
      .i_period    (period),
      .o_rd_req    (ply_req),
      .o_rd_addr   (ply_addr),
      .i_rd_ack    (ply_ack),
      .i_ram_rdata (ram_rdata),
      .o_shift     (shift)
   );

   fm_nco fm_nco_inst (
      .pll_clk (pll_clk),
      .i_nrst  (i_nrst),
      .i_shift (shift),
      .i_set   (fm_set),
      .o_fm    (o_fm)
   );

endmodule

/* fm_tx_sva.sv */
`timescale 1ns/1ns
module fm_tx_sva (
   input logic pll_clk,
   input logic i_nrst,
   input logic i_req0,
   input logic i_ack0,
   input logic i_req1,
   input logic i_ack1
);

   // Failed assertion count, read by the testbench at the end of the run
   int fail_cnt = 0;

   // One grant at a time
   a_one_ack: assert property (@(posedge pll_clk) disable iff (!i_nrst)
      !(i_ack0 && i_ack1))
      else begin
         fail_cnt++;
         $error("ack0 and ack1 high together");
      end

   // Ack rises only for a waiting requester
   a_ack0_req: assert property (@(posedge pll_clk) disable iff (!i_nrst)
      $rose(i_ack0) |-> i_req0)
      else begin
         fail_cnt++;
         $error("ack0 rose without req0");
      end
   a_ack1_req: assert property (@(posedge pll_clk) disable iff (!i_nrst)
      $rose(i_ack1) |-> i_req1)
      else begin
         fail_cnt++;
         $error("ack1 rose without req1");
      end

   // Request held until acked
   a_hold0: assert property (@(posedge pll_clk) disable iff (!i_nrst)
      i_req0 && !i_ack0 |=> i_req0)
      else begin
         fail_cnt++;
         $error("req0 dropped before ack0");
      end
   a_hold1: assert property (@(posedge pll_clk) disable iff (!i_nrst)
      i_req1 && !i_ack1 |=> i_req1)
      else begin
         fail_cnt++;
         $error("req1 dropped before ack1");
      end

   // Ack follows req down one clock later
   a_drop0: assert property (@(posedge pll_clk) disable iff (!i_nrst)
      $fell(i_req0) |=> !i_ack0)
      else begin
         fail_cnt++;
         $error("ack0 still high after req0 fell");
      end
   a_drop1: assert property (@(posedge pll_clk) disable iff (!i_nrst)
      $fell(i_req1) |=> !i_ack1)
      else begin
         fail_cnt++;
         $error("ack1 still high after req1 fell");
      end

endmodule

bind arb_rr2 fm_tx_sva fm_tx_sva_inst (
   .pll_clk (pll_clk),
   .i_nrst  (i_nrst),
   .i_req0  (i_req0),
   .i_ack0  (o_ack0),
   .i_req1  (i_req1),
   .i_ack1  (o_ack1)
);

/* tb_fm_tx.sv */
`timescale 1ns/1ns
module tb_fm_tx import fm_cfg_pkg::*, uart_pkg::*; ();

   localparam int          NUM_WORDS   = 6;
   localparam int          GAP_CLKS    = 4;
   localparam int          FRAME_CLKS  = (UART_DATA_BITS + 2) * UART_CLKS_PER_BIT + GAP_CLKS;
   localparam int          WINDOW_CLKS = 20000;
   localparam int          SETTLE_CLKS = 100;
   // Write bytes, three read passes, frequency commands and two reply frames per read
   localparam int          NUM_FRAMES  = NUM_WORDS * (2 * 8 + 3 * 10) + 20 + 6 * NUM_WORDS;
   localparam int          LIMIT_CLKS  =
      2 * (NUM_FRAMES * FRAME_CLKS + 3 * (WINDOW_CLKS + SETTLE_CLKS));
   localparam logic [31:0] SEED        = 32'd20278;

   logic        pll_clk;
   logic        i_nrst;
   logic        i_rx;
   logic        o_tx;
   logic        o_fm;
   logic [31:0] rng;
   logic [7:0]  tx_bytes [$];
   logic        set_sent = 1'b0;
   logic        tx_sent  = 1'b0;
   int          cycles   = 0;
   int          checks   = 0;
   int          errors   = 0;

   fm_tx_top fm_tx_top_inst (
      .pll_clk (pll_clk),
      .i_nrst  (i_nrst),
      .i_rx    (i_rx),
      .o_tx    (o_tx),
      .o_fm    (o_fm)
   );

   initial begin
      pll_clk = 1'b0;
      forever #50 pll_clk = ~pll_clk;
   end

   always @(posedge pll_clk) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT_CLKS) begin
         $display("Timeout after %0d cycles, the test sequence did not complete", cycles);
         $display("Regression failed");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic log_error(input string msg);
      errors++;
      $display("Error at %0t ns: %s", $time, msg);
   endtask

   //////////////////////////////
   // Serial stimulus
   task automatic send_byte(input logic [7:0] b);
      logic [UART_DATA_BITS+1:0] frame;
      frame = {1'b1, b, 1'b0};
      for (int i = 0; i < UART_DATA_BITS + 2; i++) begin
         i_rx = frame[i];
         repeat (UART_CLKS_PER_BIT) @(negedge pll_clk);
      end
      repeat (GAP_CLKS) @(negedge pll_clk);
   endtask

   task automatic send_cmd(input logic [3:0] code, input logic [3:0] nib);
      if (code == CMD_SET)
         set_sent = 1'b1;
      if (code == CMD_TXLO || code == CMD_TXHI)
         tx_sent = 1'b1;
      send_byte({nib, code});
   endtask

   task automatic load_addr(input logic [RAM_AW-1:0] addr);
      send_cmd(CMD_ADDR0, addr[3:0]);
      send_cmd(CMD_ADDR1, addr[7:4]);
      send_cmd(CMD_ADDR2, {1'b0, addr[10:8]});
   endtask

   task automatic load_data(input logic [RAM_DW-1:0] word);
      send_cmd(CMD_DATA0, word[3:0]);
      send_cmd(CMD_DATA1, word[7:4]);
      send_cmd(CMD_DATA2, word[11:8]);
      send_cmd(CMD_DATA3, word[15:12]);
   endtask

   task automatic write_word(input logic [RAM_AW-1:0] addr, input logic [RAM_DW-1:0] word);
      load_addr(addr);
      load_data(word);
      send_cmd(CMD_WRITE, 4'h0);
   endtask

   task automatic pop_tx_byte(output logic [7:0] b);
      while (tx_bytes.size() == 0)
         @(negedge pll_clk);
      b = tx_bytes.pop_front();
   endtask

   // Data nibbles cleared first so the reply shows the RAM word
   task automatic read_word(input logic [RAM_AW-1:0] addr, output logic [RAM_DW-1:0] word);
      logic [7:0] lo;
      logic [7:0] hi;
      load_addr(addr);
      load_data('0);
      send_cmd(CMD_READ, 4'h0);
      send_cmd(CMD_TXLO, 4'h0);
      pop_tx_byte(lo);
      send_cmd(CMD_TXHI, 4'h0);
      pop_tx_byte(hi);
      word = {hi, lo};
   endtask

   // Serial monitor on o_tx, samples mid bit
   initial begin : tx_monitor
      logic [7:0] b;
      @(posedge i_nrst);
      forever begin
         @(negedge pll_clk);
         if (o_tx == 1'b0) begin
            repeat (UART_CLKS_PER_BIT / 2) @(negedge pll_clk);
            for (int i = 0; i < UART_DATA_BITS; i++) begin
               repeat (UART_CLKS_PER_BIT) @(negedge pll_clk);
               b[i] = o_tx;
            end
            repeat (UART_CLKS_PER_BIT) @(negedge pll_clk);
            assert (o_tx == 1'b1) else log_error("stop bit on o_tx is low");
            tx_bytes.push_back(b);
         end
      end
   end

   //////////////////////////////
   // Reference models and checks
   always @(negedge pll_clk) begin
      if (i_nrst) begin
         if (!set_sent)
            assert (o_fm == 1'b0) else log_error("o_fm moved before any CMD_SET");
         if (!tx_sent)
            assert (o_tx == 1'b1) else log_error("o_tx left idle before any transmit command");
      end
   end

   // Wraps of an accumulator adding 2*f per clock modulo the clock rate
   function automatic int expected_toggles(input logic [SHIFT_W-1:0] shift);
      longint f;
      f = longint'(FM_BASE_HZ) + longint'(shift);
      return int'(longint'(WINDOW_CLKS) * 2 * f / longint'(FM_CLK_HZ));
   endfunction

   task automatic count_toggles(output int n);
      logic prev;
      n    = 0;
      prev = o_fm;
      repeat (WINDOW_CLKS) begin
         @(negedge pll_clk);
         if (o_fm != prev)
            n++;
         prev = o_fm;
      end
   endtask

   task automatic check_word(input logic [RAM_AW-1:0] addr, input logic [RAM_DW-1:0] want,
                             input logic [RAM_DW-1:0] got);
      checks++;
      assert (got == want)
         else log_error($sformatf("address 0x%03h read 0x%04h, expected 0x%04h",
                                  addr, got, want));
   endtask

   task automatic check_toggles(input logic [SHIFT_W-1:0] shift);
      int want;
      int n;
      repeat (SETTLE_CLKS) @(negedge pll_clk);
      count_toggles(n);
      want = expected_toggles(shift);
      checks++;
      assert (n >= want - 1 && n <= want + 1)
         else log_error($sformatf("%0d o_fm toggles for shift %0d, expected %0d",
                                  n, shift, want));
   endtask

   //////////////////////////////
   // Test sequence
   initial begin : test_seq
      logic [RAM_AW-1:0]  addrs [NUM_WORDS];
      logic [RAM_DW-1:0]  words [NUM_WORDS];
      logic [RAM_DW-1:0]  got;
      logic [SHIFT_W-1:0] shift_a;
      logic [SHIFT_W-1:0] shift_b;
      int                 sva_fails;
      i_nrst = 1'b0;
      i_rx   = 1'b1;
      rng    = SEED;
      repeat (5) @(negedge pll_clk);
      i_nrst = 1'b1;
      // Quiet line, carrier off
      repeat (4 * UART_CLKS_PER_BIT) @(negedge pll_clk);

      // Player halted, plain write and read back
      for (int i = 0; i < NUM_WORDS; i++) begin
         rng      = xorshift32(rng);
         addrs[i] = {rng[10:3], 3'(i + 1)};
         words[i] = rng[31:16];
         write_word(addrs[i], words[i]);
      end
      for (int i = 0; i < NUM_WORDS; i++) begin
         read_word(addrs[i], got);
         check_word(addrs[i], words[i], got);
      end

      // Shifts far enough apart to tell the counts apart
      rng     = xorshift32(rng);
      shift_a = {3'b000, rng[11:0]};
      shift_b = {3'b110, rng[23:12]};
      write_word('0, {1'b1, shift_a});
      send_cmd(CMD_PER0, 4'h4);
      send_cmd(CMD_SET, 4'h0);
      check_toggles(shift_a);

      // Played but not latched yet
      write_word('0, {1'b1, shift_b});
      check_toggles(shift_a);
      send_cmd(CMD_SET, 4'h0);
      check_toggles(shift_b);

      // Player reading every other clock
      send_cmd(CMD_PER0, 4'h1);
      for (int i = 0; i < NUM_WORDS; i++) begin
         rng      = xorshift32(rng);
         addrs[i] = {rng[12:5], 3'(i + 1)};
         words[i] = rng[31:16];
         write_word(addrs[i], words[i]);
      end
      for (int pass = 0; pass < 2; pass++) begin
         for (int i = 0; i < NUM_WORDS; i++) begin
            read_word(addrs[i], got);
            check_word(addrs[i], words[i], got);
         end
      end

      sva_fails = fm_tx_top_inst.arb_rr2_inst.fm_tx_sva_inst.fail_cnt;
      $display("Checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, sva_fails);
      if (errors == 0 && sva_fails == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

/* vlog.f */
fm_cfg_pkg.sv
uart_pkg.sv
uart_txrx.sv
cmd_decoder.sv
arb_rr2.sv
sample_ram.sv
fm_player.sv
fm_nco.sv
fm_tx_top.sv
fm_tx_sva.sv
tb_fm_tx.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --top-module tb_fm_tx -f vlog.f -o tb_fm_tx \
   && ./obj_dir/tb_fm_tx > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "^Regression passed$" sim.log \
   && { echo "Simulation PASSED"; exit 0; } \
   || { echo "Simulation FAILED"; exit 1; }
